//--- Bender.yml
package:
  name: uart_string_handle

sources:
  - files:
      - hdl/uart_string_pkg.sv
      - hdl/uart_baud_timer.sv
      - hdl/uart_tx.sv
      - hdl/uart_rx.sv
      - hdl/frame_tx_fsm.sv
      - hdl/frame_rx_fsm.sv
      - hdl/uart_string_handle.sv
  - target: test
    files:
      - verification/tb_uart_string_handle.sv

//--- files.f
hdl/uart_string_pkg.sv
hdl/uart_baud_timer.sv
hdl/uart_tx.sv
hdl/uart_rx.sv
hdl/frame_tx_fsm.sv
hdl/frame_rx_fsm.sv
hdl/uart_string_handle.sv
verification/tb_uart_string_handle.sv

//--- hdl/frame_rx_fsm.sv
/*
  finds &&content&& in the byte stream and packs content into rx_string
  a lone '&' inside content is kept, characters past MAX_CHARS are dropped
  rx_length updates at rx_done, rx_string is written as bytes arrive
*/
`timescale 1ns/10ps
`default_nettype none

module frame_rx_fsm (
	input  logic                               sys_clk,
	input  logic                               sys_rst_n,
	input  logic [7:0]                         rx_byte,
	input  logic                               rx_vld,
	output logic [uart_string_pkg::STR_W-1:0]  rx_string,
	output logic [uart_string_pkg::LEN_W-1:0]  rx_length,
	output logic                               rx_busy,
	output logic                               rx_done
);
	import uart_string_pkg::*;

	typedef enum logic [2:0] {s_idle, s_start1, s_content, s_end1, s_finish} state_t;

	state_t           state;
	logic [LEN_W-1:0] wr_len;     // characters stored in this frame
	logic [LEN_W-1:0] nxt_len;
	logic             is_amp;

	assign is_amp  = (rx_byte == FRAME_CHAR);
	assign nxt_len = wr_len + 1'b1;
	assign rx_busy = (state != s_idle);
	assign rx_done = (state == s_finish);

	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			state <= s_idle;
		end else begin
			case (state)
				s_idle:    if (rx_vld && is_amp) state <= s_start1;
				s_start1:  if (rx_vld) state <= is_amp ? s_content : s_idle;
				s_content: if (rx_vld && is_amp) state <= s_end1;
				s_end1:    if (rx_vld) state <= is_amp ? s_finish : s_content;
				s_finish:  state <= s_idle;
				default:   state <= s_idle;
			endcase
		end
	end

	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			wr_len    <= '0;
			rx_length <= '0;
			rx_string <= '0;
		end else if (rx_vld) begin
			case (state)
				s_start1:
					if (is_amp)
						wr_len <= '0; // frame opens
				s_content:
					if (!is_amp && wr_len < MAX_CHARS) begin
						rx_string[wr_len * 8 +: 8] <= rx_byte;
						wr_len <= nxt_len;
					end
				s_end1:
					if (is_amp) begin
						rx_length <= wr_len;
					end else begin
						// lone '&' was content after all
						if (wr_len < MAX_CHARS)
							rx_string[wr_len * 8 +: 8] <= FRAME_CHAR;
						if (nxt_len < MAX_CHARS)
							rx_string[nxt_len * 8 +: 8] <= rx_byte;
						wr_len <= (nxt_len < MAX_CHARS) ? nxt_len + 1'b1 : LEN_W'(MAX_CHARS);
					end
				default: ;
			endcase
		end
	end

	a_len_max: assert property (
		@(posedge sys_clk) disable iff (!sys_rst_n) rx_length <= MAX_CHARS
	);

endmodule

`default_nettype wire

//--- hdl/frame_tx_fsm.sv
/*
  sends &&, tx_length characters, then && through uart_tx
  string and length are latched on tx_req, tx_length must be 1..MAX_CHARS
*/
`timescale 1ns/10ps
`default_nettype none

module frame_tx_fsm (
	input  logic                               sys_clk,
	input  logic                               sys_rst_n,
	input  logic [uart_string_pkg::STR_W-1:0]  tx_string,
	input  logic [uart_string_pkg::LEN_W-1:0]  tx_length,
	input  logic                               tx_req,
	output logic                               tx_busy,
	output logic                               tx_done,
	output logic [7:0]                         byte_data,
	output logic                               byte_req,
	input  logic                               byte_done
);
	import uart_string_pkg::*;

	typedef enum logic [2:0] {
		s_idle, s_start1, s_start2, s_content, s_end1, s_end2, s_finish
	} state_t;

	state_t           state;
	logic [STR_W-1:0] str_q;
	logic [LEN_W-1:0] len_q;
	logic [LEN_W-1:0] idx;        // next character to send
	logic             send;
	logic [7:0]       next_byte;

	assign tx_busy = (state != s_idle);
	assign tx_done = (state == s_finish);

	// a new byte goes out on accept and after every byte but the last '&'
	assign send = (state == s_idle) ? tx_req :
		(byte_done && (state inside {s_start1, s_start2, s_content, s_end1}));

	always_comb begin
		next_byte = FRAME_CHAR;
		if (state == s_start2 || (state == s_content && idx != len_q))
			next_byte = str_q[idx * 8 +: 8];
	end

	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			state    <= s_idle;
			idx      <= '0;
			byte_req <= 1'b0;
		end else begin
			byte_req <= send;
			case (state)
				s_idle: begin
					idx <= '0;
					if (tx_req)
						state <= s_start1;
				end
				s_start1: if (byte_done) state <= s_start2;
				s_start2:
					if (byte_done) begin
						state <= s_content; // character 0 already queued
						idx   <= idx + 1'b1;
					end
				s_content:
					if (byte_done) begin
						if (idx == len_q)
							state <= s_end1;
						else
							idx <= idx + 1'b1;
					end
				s_end1:   if (byte_done) state <= s_end2;
				s_end2:   if (byte_done) state <= s_finish;
				s_finish: state <= s_idle;
				default:  state <= s_idle;
			endcase
		end
	end

	always_ff @(posedge sys_clk) begin
		if (state == s_idle && tx_req) begin
			str_q <= tx_string;
			len_q <= tx_length;
		end
		if (send)
			byte_data <= next_byte;
	end

	a_len_range: assert property (
		@(posedge sys_clk) disable iff (!sys_rst_n)
		(state == s_idle && tx_req) |-> (tx_length >= 1 && tx_length <= MAX_CHARS)
	);

endmodule

`default_nettype wire

//--- hdl/uart_baud_timer.sv
/*
  bit-period tick for the serial engines, one tick per CLKS_PER_BIT clocks
  half is taken while run is low and shortens only the first period
*/
`timescale 1ns/10ps
`default_nettype none

module uart_baud_timer (
	input  logic sys_clk,
	input  logic sys_rst_n,
	input  logic run,
	input  logic half,
	output logic tick
);
	import uart_string_pkg::*;

	logic [CNT_W-1:0] cnt;

	// cnt preloads while stopped so the first tick lands on the bit edge
	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			cnt  <= CNT_W'(1);
			tick <= 1'b0;
		end else if (!run) begin
			cnt  <= half ? CNT_W'(CLKS_PER_BIT / 2 + 1) : CNT_W'(1);
			tick <= 1'b0;
		end else if (cnt == CNT_W'(CLKS_PER_BIT - 1)) begin
			cnt  <= '0;   // wrap, next period is a full bit
			tick <= 1'b1;
		end else begin
			cnt  <= cnt + 1'b1;
			tick <= 1'b0;
		end
	end

	// users only leave their running state on a tick
	a_tick_while_run: assert property (
		@(posedge sys_clk) disable iff (!sys_rst_n) tick |-> run
	);

endmodule

`default_nettype wire

//--- hdl/uart_rx.sv
/*
  8N1 deserializer, samples at mid-bit after a start-bit recheck
  rx_vld pulses at mid-stop only when the stop bit reads high
  no back-pressure, rx_byte is valid in the rx_vld cycle
*/
`timescale 1ns/10ps
`default_nettype none

module uart_rx (
	input  logic       sys_clk,
	input  logic       sys_rst_n,
	input  logic       rxd,
	output logic [7:0] rx_byte,
	output logic       rx_vld
);

	typedef enum logic [1:0] {s_idle, s_start, s_data, s_stop} state_t;

	state_t     state;
	logic       rxd_meta;
	logic       rxd_sync;
	logic       rxd_prev;
	logic [2:0] bit_cnt;
	logic [7:0] shreg;
	logic       tick;
	logic       run;

	assign run = (state != s_idle);

	uart_baud_timer u_timer (
		.sys_clk   (sys_clk),
		.sys_rst_n (sys_rst_n),
		.run       (run),
		.half      (1'b1),   // first tick at mid start bit
		.tick      (tick)
	);

	// two-flop sync plus one more for the edge
	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			rxd_meta <= 1'b1;
			rxd_sync <= 1'b1;
			rxd_prev <= 1'b1;
		end else begin
			rxd_meta <= rxd;
			rxd_sync <= rxd_meta;
			rxd_prev <= rxd_sync;
		end
	end

	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			state   <= s_idle;
			bit_cnt <= '0;
			rx_vld  <= 1'b0;
		end else begin
			rx_vld <= 1'b0;
			case (state)
				s_idle:
					if (rxd_prev && !rxd_sync)
						state <= s_start;
				s_start:
					if (tick) begin
						state   <= rxd_sync ? s_idle : s_data; // glitch, not a start
						bit_cnt <= '0;
					end
				s_data:
					if (tick) begin
						bit_cnt <= bit_cnt + 1'b1;
						if (bit_cnt == 3'd7)
							state <= s_stop;
					end
				s_stop:
					if (tick) begin
						state  <= s_idle;
						rx_vld <= rxd_sync; // framing error drops the byte
					end
				default: state <= s_idle;
			endcase
		end
	end

	always_ff @(posedge sys_clk) begin
		if (state == s_data && tick)
			shreg <= {rxd_sync, shreg[7:1]}; // lsb first
		if (state == s_stop && tick)
			rx_byte <= shreg;
	end

endmodule

`default_nettype wire

//--- hdl/uart_string_handle.sv
/*
  UART string link top, framed as &&content&& at a fixed 8N1 bit time
  transmit and receive run independently on sys_clk
*/
`timescale 1ns/10ps
`default_nettype none

module uart_string_handle (
	input  logic                               sys_clk,
	input  logic                               sys_rst_n,
	input  logic [uart_string_pkg::STR_W-1:0]  tx_string,
	input  logic [uart_string_pkg::LEN_W-1:0]  tx_length,
	input  logic                               tx_req,
	output logic                               tx_busy,
	output logic                               tx_done,
	output logic [uart_string_pkg::STR_W-1:0]  rx_string,
	output logic [uart_string_pkg::LEN_W-1:0]  rx_length,
	output logic                               rx_busy,
	output logic                               rx_done,
	input  logic                               uart_rx_port,
	output logic                               uart_tx_port
);

	logic [7:0] byte_data;
	logic       byte_req;
	logic       byte_done;
	logic [7:0] rx_byte;
	logic       rx_vld;

	frame_tx_fsm u_frame_tx (
		.sys_clk   (sys_clk),
		.sys_rst_n (sys_rst_n),
		.tx_string (tx_string),
		.tx_length (tx_length),
		.tx_req    (tx_req),
		.tx_busy   (tx_busy),
		.tx_done   (tx_done),
		.byte_data (byte_data),
		.byte_req  (byte_req),
		.byte_done (byte_done)
	);

	uart_tx u_uart_tx (
		.sys_clk   (sys_clk),
		.sys_rst_n (sys_rst_n),
		.byte_data (byte_data),
		.byte_req  (byte_req),
		.txd       (uart_tx_port),
		.byte_done (byte_done)
	);

	uart_rx u_uart_rx (
		.sys_clk   (sys_clk),
		.sys_rst_n (sys_rst_n),
		.rxd       (uart_rx_port),
		.rx_byte   (rx_byte),
		.rx_vld    (rx_vld)
	);

	frame_rx_fsm u_frame_rx (
		.sys_clk   (sys_clk),
		.sys_rst_n (sys_rst_n),
		.rx_byte   (rx_byte),
		.rx_vld    (rx_vld),
		.rx_string (rx_string),
		.rx_length (rx_length),
		.rx_busy   (rx_busy),
		.rx_done   (rx_done)
	);

endmodule

`default_nettype wire

//--- hdl/uart_string_pkg.sv
/*
  constants shared by the UART string link
  bit time is fixed at elaboration and kept short for simulation
  strings are MAX_CHARS bytes, character i in bits 8i+7 down to 8i
*/
`default_nettype none

package uart_string_pkg;

	// serial timing, 8N1 only
	localparam int CLKS_PER_BIT = 16;
	localparam int CNT_W        = $clog2(CLKS_PER_BIT);

	// string geometry
	localparam int MAX_CHARS = 128;
	localparam int STR_W     = MAX_CHARS * 8;
	localparam int LEN_W     = 8;                  // holds 0..MAX_CHARS

	// frame delimiter, sent twice at each end
	localparam logic [7:0] FRAME_CHAR = 8'h26;     // '&'

endpackage

`default_nettype wire

//--- hdl/uart_tx.sv
/*
  8N1 serializer, LSB first, line idles high
  byte_req is taken only while idle, byte_done comes 10 bit times later
*/
`timescale 1ns/10ps
`default_nettype none

module uart_tx (
	input  logic       sys_clk,
	input  logic       sys_rst_n,
	input  logic [7:0] byte_data,
	input  logic       byte_req,
	output logic       txd,
	output logic       byte_done
);

	logic       busy;
	logic [3:0] bit_cnt;   // bits finished, 0 = start bit on the line
	logic [8:0] shreg;     // data then stop
	logic       tick;

	uart_baud_timer u_timer (
		.sys_clk   (sys_clk),
		.sys_rst_n (sys_rst_n),
		.run       (busy),
		.half      (1'b0),
		.tick      (tick)
	);

	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			busy      <= 1'b0;
			bit_cnt   <= '0;
			txd       <= 1'b1;
			byte_done <= 1'b0;
		end else begin
			byte_done <= 1'b0;
			if (!busy) begin
				if (byte_req) begin
					busy    <= 1'b1;
					bit_cnt <= '0;
					txd     <= 1'b0; // start bit
				end
			end else if (tick) begin
				if (bit_cnt == 4'd9) begin
					busy      <= 1'b0; // end of stop bit
					byte_done <= 1'b1;
					txd       <= 1'b1;
				end else begin
					bit_cnt <= bit_cnt + 1'b1;
					txd     <= shreg[0];
				end
			end
		end
	end

	always_ff @(posedge sys_clk) begin
		if (!busy && byte_req)
			shreg <= {1'b1, byte_data};
		else if (busy && tick)
			shreg <= {1'b1, shreg[8:1]};
	end

	a_req_when_idle: assert property (
		@(posedge sys_clk) disable iff (!sys_rst_n) byte_req |-> !busy
	);

endmodule

`default_nettype wire

//--- verification/string_golden.txt
# T length hex_string  (loopback send, character 0 in the last two digits)
# R byte_count raw_bytes... expected_length expected_hex_string  (bit-banged receive)
T 1 5a
T 5 6f6c6c6548
T 128 4f4e4d4c4b4a494847464544434241404f4e4d4c4b4a494847464544434241404f4e4d4c4b4a494847464544434241404f4e4d4c4b4a494847464544434241404f4e4d4c4b4a494847464544434241404f4e4d4c4b4a494847464544434241404f4e4d4c4b4a494847464544434241404f4e4d4c4b4a49484746454443424140
R 7 26 26 41 26 42 26 26 3 422641
R 8 26 41 26 26 43 44 26 26 2 4443
R 134
26 26
40 41 42 43 44 45 46 47 48 49 4a 4b 4c 4d 4e 4f 40 41 42 43 44 45 46 47 48 49 4a 4b 4c 4d 4e 4f
40 41 42 43 44 45 46 47 48 49 4a 4b 4c 4d 4e 4f 40 41 42 43 44 45 46 47 48 49 4a 4b 4c 4d 4e 4f
40 41 42 43 44 45 46 47 48 49 4a 4b 4c 4d 4e 4f 40 41 42 43 44 45 46 47 48 49 4a 4b 4c 4d 4e 4f
40 41 42 43 44 45 46 47 48 49 4a 4b 4c 4d 4e 4f 40 41 42 43 44 45 46 47 48 49 4a 4b 4c 4d 4e 4f
58 59 26 26
128 4f4e4d4c4b4a494847464544434241404f4e4d4c4b4a494847464544434241404f4e4d4c4b4a494847464544434241404f4e4d4c4b4a494847464544434241404f4e4d4c4b4a494847464544434241404f4e4d4c4b4a494847464544434241404f4e4d4c4b4a494847464544434241404f4e4d4c4b4a49484746454443424140
T 3 622661

//--- verification/tb_uart_string_handle.sv
/*
  testbench for the UART string link, cases come from verification/string_golden.txt
  T cases loop uart_tx_port back to uart_rx_port, R cases bit-bang raw bytes
  only the first rx_length characters of rx_string are compared
*/
`timescale 1ns/10ps
`default_nettype none

module tb_uart_string_handle;
	import uart_string_pkg::*;

	logic             sys_clk;
	logic             sys_rst_n;
	logic [STR_W-1:0] tx_string;
	logic [LEN_W-1:0] tx_length;
	logic             tx_req;
	logic             tx_busy;
	logic             tx_done;
	logic [STR_W-1:0] rx_string;
	logic [LEN_W-1:0] rx_length;
	logic             rx_busy;
	logic             rx_done;
	logic             uart_rx_port;
	logic             uart_tx_port;
	logic             loop_sel;        // 1 = loopback, 0 = bit-bang
	logic             bb_line;
	logic [15:0]      lfsr;
	logic [7:0]       raw_mem [0:255];
	int               raw_cnt;
	int               rx_done_cnt;
	int               n_checks;
	int               n_errors;
	int               n_timeouts;

	uart_string_handle dut_i (.*);

	assign uart_rx_port = loop_sel ? uart_tx_port : bb_line;

	initial begin
		sys_clk = 1'b0;
		forever #4 sys_clk = ~sys_clk;
	end

	always @(posedge sys_clk)
		if (rx_done)
			rx_done_cnt <= rx_done_cnt + 1;

	// galois form, taps 16,14,13,11
	function automatic logic [15:0] lfsr_step(input logic [15:0] s);
		return s[0] ? ((s >> 1) ^ 16'hb400) : (s >> 1);
	endfunction

	task automatic take_bits(input int n, output int val);
		int k;
		val = 0;
		for (k = 0; k < n; k++) begin
			lfsr = lfsr_step(lfsr);
			val  = (val << 1) | lfsr[0];
		end
	endtask

	task automatic compare_value(input string name, input logic [31:0] got, input logic [31:0] exp);
		n_checks++;
		assert (got === exp) else begin
			n_errors++;
			$display("MISMATCH %s exp %h got %h", name, exp, got);
		end
	endtask

	task automatic compare_string(input int len, input logic [STR_W-1:0] exp);
		int i;
		for (i = 0; i < len; i++)
			compare_value($sformatf("rx_string[%0d]", i), rx_string[i*8 +: 8], exp[i*8 +: 8]);
	endtask

	// start bit, 8 data bits lsb first, stop bit
	task automatic send_byte(input logic [7:0] data);
		logic [9:0] frame;
		int         k;
		frame = {1'b1, data, 1'b0};
		for (k = 0; k < 10; k++) begin
			@(posedge sys_clk);
			bb_line <= frame[k];
			repeat (CLKS_PER_BIT - 1) @(posedge sys_clk);
		end
	endtask

	task automatic wait_tx_done(input int limit);
		int n;
		n = 0;
		@(negedge sys_clk);
		while (!tx_done && n < limit) begin
			compare_value("tx_busy", tx_busy, 1'b1);
			@(negedge sys_clk);
			n++;
		end
		assert (tx_done) else begin
			n_timeouts++;
			$display("timeout while waiting for tx_done");
		end
	endtask

	// rx_done may already have come, so watch the counter
	task automatic wait_rx_done(input int start, input int limit);
		int n;
		n = 0;
		while (rx_done_cnt == start && n < limit) begin
			@(negedge sys_clk);
			n++;
		end
		assert (rx_done_cnt != start) else begin
			n_timeouts++;
			$display("timeout while waiting for rx_done");
		end
		repeat (2 * CLKS_PER_BIT) @(negedge sys_clk);
		compare_value("rx_done count", rx_done_cnt - start, 1);
		compare_value("rx_busy", rx_busy, 1'b0);
	endtask

	task automatic run_loopback(input int len, input logic [STR_W-1:0] str);
		int start;
		int k;
		start = rx_done_cnt;
		@(posedge sys_clk);
		loop_sel  <= 1'b1;
		tx_string <= str;
		tx_length <= len;
		tx_req    <= 1'b1;
		@(posedge sys_clk);
		tx_req <= 1'b0;
		@(negedge sys_clk);
		compare_value("tx_busy", tx_busy, 1'b1);
		@(posedge sys_clk);
		tx_req    <= 1'b1;   // ignored while busy
		tx_string <= ~str;
		@(posedge sys_clk);
		tx_req <= 1'b0;
		wait_tx_done((len + 6) * 10 * CLKS_PER_BIT + 200);
		for (k = 0; k < 2 * CLKS_PER_BIT; k++) begin
			@(negedge sys_clk);
			compare_value("tx_busy", tx_busy, 1'b0); // no second send follows
		end
		wait_rx_done(start, 40 * CLKS_PER_BIT);
		compare_value("rx_length", rx_length, len);
		compare_string(len, str);
	endtask

	task automatic run_receive(input int exp_len, input logic [STR_W-1:0] exp_str);
		int start;
		int gap;
		int k;
		start = rx_done_cnt;
		@(posedge sys_clk);
		loop_sel <= 1'b0;
		for (k = 0; k < raw_cnt; k++) begin
			send_byte(raw_mem[k]);
			take_bits(4, gap);
			repeat (gap) @(posedge sys_clk);
		end
		wait_rx_done(start, 40 * CLKS_PER_BIT);
		compare_value("rx_length", rx_length, exp_len);
		compare_string(exp_len, exp_str);
	endtask

	initial begin
		int                fd;
		int                code;
		int                len;
		int                k;
		logic [8*16-1:0]   tag;
		logic [8*128-1:0]  line_buf;
		logic [STR_W-1:0]  gold;
		sys_rst_n   = 1'b0;
		tx_string   = '0;
		tx_length   = '0;
		tx_req      = 1'b0;
		loop_sel    = 1'b1;
		bb_line     = 1'b1;
		lfsr        = 16'd2442;
		rx_done_cnt = 0;
		n_checks    = 0;
		n_errors    = 0;
		n_timeouts  = 0;
		repeat (4) @(posedge sys_clk);
		sys_rst_n <= 1'b1;
		@(negedge sys_clk);
		compare_value("tx_busy", tx_busy, 1'b0);
		compare_value("tx_done", tx_done, 1'b0);
		compare_value("rx_busy", rx_busy, 1'b0);
		compare_value("rx_done", rx_done, 1'b0);
		compare_value("uart_tx_port", uart_tx_port, 1'b1);
		compare_value("rx_length", rx_length, 0);

		fd = $fopen("verification/string_golden.txt", "r");
		assert (fd != 0) else begin
			n_errors++;
			$display("could not open the golden data file");
		end
		code = (fd != 0) ? $fscanf(fd, "%s", tag) : 0;
		while (code == 1) begin
			if (tag == "#") begin
				code = $fgets(line_buf, fd);   // comment line
			end else if (tag == "T") begin
				code = $fscanf(fd, "%d %h", len, gold);
				run_loopback(len, gold);
			end else begin
				code = $fscanf(fd, "%d", raw_cnt);
				for (k = 0; k < raw_cnt; k++)
					code = $fscanf(fd, "%h", raw_mem[k]);
				code = $fscanf(fd, "%d %h", len, gold);
				run_receive(len, gold);
			end
			code = $fscanf(fd, "%s", tag);
		end
		if (fd != 0)
			$fclose(fd);

		$display("checks %0d errors %0d timeouts %0d", n_checks, n_errors, n_timeouts);
		if (n_errors == 0 && n_timeouts == 0) begin
			$display("TB PASSED");
		end else begin
			$display("TB FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire
